//--- design/csr_pkg.sv
// machine CSR bus and register types
package csr_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTIMECMP = 12'h7c0; // custom machine r/w range

  localparam logic [1:0] MPP_USER    = 2'b00;
  localparam logic [1:0] MPP_MACHINE = 2'b11;

  // one master's request on the shared bus
  typedef struct packed {
    csr_addr_t addr;
    logic      ren;
    logic      wen;
    xlen_t     wdata;
  } csr_req_t;

  localparam csr_req_t CSR_REQ_IDLE = '0;

  typedef struct packed {
    logic [63:13] rsv_hi;
    logic [1:0]   mpp;     // previous privilege
    logic [10:8]  rsv_mid;
    logic         mpie;
    logic [6:4]   rsv_lo;
    logic         mie;     // global machine interrupt enable
    logic [2:0]   rsv_base;
  } mstatus_fields_t;

  typedef union packed {
    xlen_t           raw;
    mstatus_fields_t f;
  } mstatus_u;

endpackage

//--- design/trap_pkg.sv
// trap opcodes, causes and sequencer states
package trap_pkg;
  import csr_pkg::*;

  typedef enum logic [7:0] {
    OP_ECALL = 8'h01,
    OP_MRET  = 8'h02,
    OP_OTHER = 8'h03
  } trap_op_t;

  localparam xlen_t CAUSE_ILLEGAL   = 64'd2;
  localparam xlen_t CAUSE_ECALL_M   = 64'd11;
  localparam xlen_t CAUSE_TIMER_INT = {1'b1, 63'd7}; // interrupt flag in msb

  // entry runs mepc, mcause, mtvec, mstatus rd, mstatus wr
  typedef enum logic [3:0] {
    ST_IDLE           = 4'd0,
    ST_ENT_MEPC       = 4'd1,
    ST_ENT_MCAUSE     = 4'd2,
    ST_ENT_MTVEC      = 4'd3,
    ST_ENT_MSTATUS_RD = 4'd4,
    ST_ENT_MSTATUS_WR = 4'd5,
    ST_RET_MSTATUS_RD = 4'd6,
    ST_RET_MEPC       = 4'd7,
    ST_RET_MSTATUS_WR = 4'd8
  } trap_state_t;

endpackage

//--- design/trap_sequencer.sv
// trap entry and return sequencer
`timescale 1ns/1ps

module trap_sequencer import csr_pkg::*; import trap_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_ena,
  input  trap_op_t i_opcode,
  input  xlen_t    i_pc,
  input  logic     i_irq,
  input  logic     i_ack,
  output logic     o_done,
  output logic     o_pc_jmp,
  output xlen_t    o_pc_jmpaddr,
  output csr_req_t o_csr_req,
  input  xlen_t    i_csr_rdata
);

  trap_state_t state;
  trap_state_t next_state;
  logic        step;       // 0 sets up the request, 1 is the bus cycle
  logic        take_ena;
  logic        take_irq;
  logic        bus_cycle;
  xlen_t       trap_pc;
  xlen_t       cause;
  xlen_t       jmp_target; // mtvec on entry, mepc on return
  mstatus_u    saved_status;
  mstatus_u    new_status;
  csr_req_t    step_req;

  assign take_ena  = (state == ST_IDLE) && !o_done && i_ena;
  assign take_irq  = (state == ST_IDLE) && !o_done && !i_ena && i_irq;
  assign bus_cycle = (state != ST_IDLE) && step;

  // updated mstatus, built through the field view
  always_comb begin
    new_status = saved_status;
    if (state == ST_RET_MSTATUS_WR) begin
      new_status.f.mpp  = MPP_USER;
      new_status.f.mpie = 1'b1;
      new_status.f.mie  = saved_status.f.mpie;
    end else begin
      new_status.f.mpp  = MPP_MACHINE;
      new_status.f.mpie = saved_status.f.mie;
      new_status.f.mie  = 1'b0;
    end
  end

  // request and successor for each step
  always_comb begin
    step_req   = CSR_REQ_IDLE;
    next_state = ST_IDLE;
    case (state)
      ST_ENT_MEPC: begin
        step_req.addr  = CSR_MEPC;
        step_req.wen   = 1'b1;
        step_req.wdata = trap_pc;
        next_state     = ST_ENT_MCAUSE;
      end
      ST_ENT_MCAUSE: begin
        step_req.addr  = CSR_MCAUSE;
        step_req.wen   = 1'b1;
        step_req.wdata = cause;
        next_state     = ST_ENT_MTVEC;
      end
      ST_ENT_MTVEC: begin
        step_req.addr = CSR_MTVEC;
        step_req.ren  = 1'b1;
        next_state    = ST_ENT_MSTATUS_RD;
      end
      ST_ENT_MSTATUS_RD: begin
        step_req.addr = CSR_MSTATUS;
        step_req.ren  = 1'b1;
        next_state    = ST_ENT_MSTATUS_WR;
      end
      ST_RET_MSTATUS_RD: begin
        step_req.addr = CSR_MSTATUS;
        step_req.ren  = 1'b1;
        next_state    = ST_RET_MEPC;
      end
      ST_RET_MEPC: begin
        step_req.addr = CSR_MEPC;
        step_req.ren  = 1'b1;
        next_state    = ST_RET_MSTATUS_WR;
      end
      ST_ENT_MSTATUS_WR, ST_RET_MSTATUS_WR: begin
        step_req.addr  = CSR_MSTATUS;
        step_req.wen   = 1'b1;
        step_req.wdata = new_status.raw;
        next_state     = ST_IDLE;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      step         <= 1'b0;
      o_csr_req    <= CSR_REQ_IDLE;
      o_pc_jmp     <= 1'b0;
      o_pc_jmpaddr <= '0;
      o_done       <= 1'b0;
    end else begin
      o_pc_jmp <= 1'b0;
      if (o_done && i_ack) begin
        o_done <= 1'b0;
      end
      if (take_ena) begin
        state <= (i_opcode == OP_MRET) ? ST_RET_MSTATUS_RD : ST_ENT_MEPC;
      end else if (take_irq) begin
        state <= ST_ENT_MEPC;
      end else if (state != ST_IDLE && !step) begin
        o_csr_req <= step_req;
        step      <= 1'b1;
      end else if (bus_cycle) begin
        o_csr_req <= CSR_REQ_IDLE;
        step      <= 1'b0;
        state     <= next_state;
        if (next_state == ST_IDLE) begin // last write done, hand off to fetch
          o_pc_jmp     <= 1'b1;
          o_pc_jmpaddr <= jmp_target;
          o_done       <= 1'b1;
        end
      end
    end
  end

  // captured values
  always_ff @(posedge clk) begin
    if (take_ena || take_irq) begin
      trap_pc <= i_pc;
    end
    if (take_irq) begin
      cause <= CAUSE_TIMER_INT;
    end else if (take_ena) begin
      cause <= (i_opcode == OP_ECALL) ? CAUSE_ECALL_M : CAUSE_ILLEGAL;
    end
    if (bus_cycle && (state == ST_ENT_MTVEC || state == ST_RET_MEPC)) begin
      jmp_target <= i_csr_rdata;
    end
    if (bus_cycle && (state == ST_ENT_MSTATUS_RD || state == ST_RET_MSTATUS_RD)) begin
      saved_status.raw <= i_csr_rdata;
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(o_csr_req.ren && o_csr_req.wen))
    else $error("csr read and write issued together");

  a_jmp_pulse: assert property (@(posedge clk) disable iff (rst)
    o_pc_jmp |=> !o_pc_jmp)
    else $error("o_pc_jmp held longer than one cycle");

endmodule

//--- design/csr_bus_arbiter.sv
// fixed-priority CSR bus arbiter
`timescale 1ns/1ps

module csr_bus_arbiter import csr_pkg::*; (
  input  csr_req_t i_trap_req,
  input  csr_req_t i_inst_req,
  output csr_req_t o_bus,
  output logic     o_inst_grant
);

  logic trap_active;
  logic inst_active;

  assign trap_active = i_trap_req.ren | i_trap_req.wen;
  assign inst_active = i_inst_req.ren | i_inst_req.wen;

  // sequencer always wins over the inst port
  assign o_inst_grant = inst_active & ~trap_active;

  always_comb begin
    if (trap_active) begin
      o_bus = i_trap_req;
    end else if (inst_active) begin
      o_bus = i_inst_req;
    end else begin
      o_bus = CSR_REQ_IDLE; // nobody on the bus
    end
  end

endmodule

//--- design/csr_file.sv
// machine CSR register file
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  csr_req_t i_bus,
  output xlen_t    o_rdata,
  output logic     o_mstatus_mie
);

  mstatus_u mstatus;
  xlen_t    mtvec;
  xlen_t    mepc;
  xlen_t    mcause;
  xlen_t    mscratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus.raw <= '0;
      mtvec       <= '0;
      mepc        <= '0;
      mcause      <= '0;
      mscratch    <= '0;
    end else if (i_bus.wen) begin
      case (i_bus.addr)
        CSR_MSTATUS:  mstatus.raw <= i_bus.wdata;
        CSR_MTVEC:    mtvec       <= {i_bus.wdata[63:2], 2'b00}; // direct mode only
        CSR_MEPC:     mepc        <= {i_bus.wdata[63:2], 2'b00};
        CSR_MCAUSE:   mcause      <= i_bus.wdata;
        CSR_MSCRATCH: mscratch    <= i_bus.wdata;
        default: ; // mtimecmp lives in the timer
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_bus.ren) begin
      case (i_bus.addr)
        CSR_MSTATUS:  o_rdata = mstatus.raw;
        CSR_MTVEC:    o_rdata = mtvec;
        CSR_MEPC:     o_rdata = mepc;
        CSR_MCAUSE:   o_rdata = mcause;
        CSR_MSCRATCH: o_rdata = mscratch;
        default:      o_rdata = '0;
      endcase
    end
  end

  assign o_mstatus_mie = mstatus.f.mie;

endmodule

//--- design/machine_timer.sv
// machine timer with compare interrupt
`timescale 1ns/1ps

module machine_timer import csr_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  csr_req_t i_bus,
  input  logic     i_mie,
  output logic     o_timer_irq
);

  xlen_t mtime;
  xlen_t mtimecmp;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime       <= '0;
      mtimecmp    <= '1; // quiet until software sets it
      o_timer_irq <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (i_bus.wen && i_bus.addr == CSR_MTIMECMP) begin
        mtimecmp <= i_bus.wdata;
      end
      o_timer_irq <= (mtime >= mtimecmp) && i_mie;
    end
  end

  // registered level, so it trails mie by one cycle
  a_irq_needs_mie: assert property (@(posedge clk) disable iff (rst)
    o_timer_irq |-> $past(i_mie))
    else $error("timer interrupt raised with mstatus.MIE low");

endmodule

//--- design/trap_unit_top.sv
// machine-mode trap unit
`timescale 1ns/1ps

module trap_unit_top import csr_pkg::*; import trap_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_ena,
  input  trap_op_t i_opcode,
  input  xlen_t    i_pc,
  input  logic     i_ack,
  output logic     o_done,
  output logic     o_pc_jmp,
  output xlen_t    o_pc_jmpaddr,
  output logic     o_timer_irq,
  input  csr_req_t i_inst_req,
  output logic     o_inst_grant,
  output xlen_t    o_csr_rdata
);

  csr_req_t trap_req;
  csr_req_t bus;
  logic     mstatus_mie;

  trap_sequencer i_trap_sequencer (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_opcode     (i_opcode),
    .i_pc         (i_pc),
    .i_irq        (o_timer_irq),
    .i_ack        (i_ack),
    .o_done       (o_done),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .o_csr_req    (trap_req),
    .i_csr_rdata  (o_csr_rdata)
  );

  csr_bus_arbiter i_csr_bus_arbiter (
    .i_trap_req   (trap_req),
    .i_inst_req   (i_inst_req),
    .o_bus        (bus),
    .o_inst_grant (o_inst_grant)
  );

  csr_file i_csr_file (
    .clk           (clk),
    .rst           (rst),
    .i_bus         (bus),
    .o_rdata       (o_csr_rdata),
    .o_mstatus_mie (mstatus_mie)
  );

  machine_timer i_machine_timer (
    .clk         (clk),
    .rst         (rst),
    .i_bus       (bus),
    .i_mie       (mstatus_mie),
    .o_timer_irq (o_timer_irq)
  );

endmodule

//--- test/trap_tb.sv
// trap unit testbench
`timescale 1ns/1ps

module trap_tb import csr_pkg::*; import trap_pkg::*; ();

  localparam int JMP_TIMEOUT   = 40;
  localparam int GRANT_TIMEOUT = 8;

  logic     clk = 1'b0;
  logic     rst;
  logic     ena;
  trap_op_t opcode;
  xlen_t    pc;
  logic     ack;
  logic     done;
  logic     pc_jmp;
  xlen_t    pc_jmpaddr;
  logic     timer_irq;
  csr_req_t inst_req;
  logic     inst_grant;
  xlen_t    csr_rdata;

  xlen_t model_csr [0:4095]; // unmapped addresses stay zero
  xlen_t mtime_model;
  int    errors;
  int    timeouts;
  int    tests;
  int    failed_tests;
  int    test_mark;

  trap_unit_top i_trap_unit_top (
    .clk (clk), .rst (rst), .i_ena (ena), .i_opcode (opcode), .i_pc (pc), .i_ack (ack),
    .o_done (done), .o_pc_jmp (pc_jmp), .o_pc_jmpaddr (pc_jmpaddr), .o_timer_irq (timer_irq),
    .i_inst_req (inst_req), .o_inst_grant (inst_grant), .o_csr_rdata (csr_rdata)
  );

  always #4 clk = ~clk;

  // free running mtime mirror
  always @(posedge clk) begin
    if (rst) begin
      mtime_model <= '0;
    end else begin
      mtime_model <= mtime_model + 64'd1;
    end
  end

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic csr_addr_t pick_csr(int idx);
    case (idx)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MEPC;
      3:       return CSR_MCAUSE;
      default: return CSR_MSCRATCH;
    endcase
  endfunction

  // MPP to machine, MPIE from MIE, MIE off
  function automatic xlen_t entry_status(xlen_t old);
    xlen_t s;
    s = old;
    s[12:11] = 2'b11;
    s[7]     = old[3];
    s[3]     = 1'b0;
    return s;
  endfunction

  function automatic xlen_t return_status(xlen_t old);
    xlen_t s;
    s = old;
    s[12:11] = 2'b00; // back to user
    s[7]     = 1'b1;
    s[3]     = old[7];
    return s;
  endfunction

  function automatic void model_write(csr_addr_t addr, xlen_t data);
    case (addr)
      CSR_MTVEC, CSR_MEPC:                   model_csr[addr] = {data[63:2], 2'b00};
      CSR_MSTATUS, CSR_MCAUSE, CSR_MSCRATCH: model_csr[addr] = data;
      default: ; // mtimecmp reads back as zero
    endcase
  endfunction

  function automatic void entry_model(xlen_t at_pc, xlen_t cause);
    model_write(CSR_MEPC, at_pc);
    model_write(CSR_MCAUSE, cause);
    model_write(CSR_MSTATUS, entry_status(model_csr[CSR_MSTATUS]));
  endfunction

  task automatic check(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timeouts++;
    $display("timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_mark) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", tests, name, (errors == test_mark) ? "ok" : "failed");
    test_mark = errors;
  endtask

  // one port access from falling edge to falling edge
  task automatic inst_access(input csr_addr_t addr, input logic wr, input xlen_t wdata,
                             output xlen_t rdata);
    int  waited;
    bit  granted;
    waited  = 0;
    granted = 1'b0;
    rdata   = '0;
    inst_req.addr  = addr;
    inst_req.ren   = !wr;
    inst_req.wen   = wr;
    inst_req.wdata = wr ? wdata : '0;
    while (!granted && waited < GRANT_TIMEOUT) begin
      #1;
      if (inst_grant) begin
        granted = 1'b1;
        rdata   = csr_rdata;
      end
      @(negedge clk);
      waited++;
    end
    inst_req = CSR_REQ_IDLE;
    if (!granted) begin
      report_timeout("o_inst_grant");
    end
  endtask

  task automatic csr_write(input csr_addr_t addr, input xlen_t data);
    xlen_t unused;
    inst_access(addr, 1'b1, data, unused);
    model_write(addr, data);
  endtask

  task automatic read_check(input csr_addr_t addr, input string what);
    xlen_t rd;
    inst_access(addr, 1'b0, '0, rd);
    check(rd, model_csr[addr], what);
  endtask

  task automatic check_trap_csrs(input string tag);
    read_check(CSR_MEPC, {tag, " mepc"});
    read_check(CSR_MCAUSE, {tag, " mcause"});
    read_check(CSR_MSTATUS, {tag, " mstatus"});
  endtask

  task automatic wait_jmp(input int limit, output int cycles);
    cycles = 1;
    while (!pc_jmp && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!pc_jmp) begin
      report_timeout("o_pc_jmp");
      cycles = 0;
    end
  endtask

  // done must hold until acked and then drop
  task automatic finish_done(input int hold);
    int n;
    check(done, 1'b1, "o_done with the jump");
    for (n = 0; n < hold; n++) begin
      @(negedge clk);
      check(pc_jmp, 1'b0, "o_pc_jmp longer than one cycle");
      check(done, 1'b1, "o_done before i_ack");
    end
    ack = 1'b1;
    n   = 0;
    while (done && n < 4) begin
      @(negedge clk);
      n++;
    end
    ack = 1'b0;
    if (done) begin
      report_timeout("o_done to fall after i_ack");
    end
  endtask

  task automatic run_trap(input trap_op_t op, input xlen_t at_pc, input int exp_cycles,
                          input xlen_t exp_addr);
    int cycles;
    opcode = op;
    pc     = at_pc;
    ena    = 1'b1;
    @(negedge clk);
    ena = 1'b0;
    wait_jmp(JMP_TIMEOUT, cycles);
    if (cycles != 0) begin
      check(cycles, exp_cycles, "cycles from i_ena to o_pc_jmp");
      check(pc_jmpaddr, exp_addr, "jump address");
    end
    finish_done($urandom_range(1, 3));
  endtask

  initial begin
    int        i;
    int        cycles;
    int        req_at;
    int        wait_cnt;
    bit        pending;
    bit        granted;
    xlen_t     trap_pc;
    csr_addr_t addr;
    void'($urandom(14));
    rst      = 1'b1;
    ena      = 1'b0;
    opcode   = OP_ECALL;
    pc       = '0;
    ack      = 1'b0;
    inst_req = CSR_REQ_IDLE;
    errors   = 0;
    timeouts = 0;
    tests    = 0;
    failed_tests = 0;
    test_mark    = 0;
    for (i = 0; i < 4096; i++) begin
      model_csr[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (i = 0; i < 12; i++) begin
      addr = pick_csr(i % 5);
      csr_write(addr, rand64());
      read_check(addr, "port readback");
    end
    read_check(CSR_MTIMECMP, "mtimecmp through csr file");
    end_test("csr port readback");

    for (i = 0; i < 3; i++) begin
      csr_write(CSR_MTVEC, rand64());
      csr_write(CSR_MSTATUS, rand64());
      trap_pc = rand64();
      run_trap(OP_ECALL, trap_pc, 11, model_csr[CSR_MTVEC]);
      entry_model(trap_pc, CAUSE_ECALL_M);
      check_trap_csrs("ecall");
    end
    end_test("ecall entry");

    for (i = 0; i < 3; i++) begin
      csr_write(CSR_MSTATUS, rand64());
      csr_write(CSR_MEPC, rand64());
      run_trap(OP_MRET, rand64(), 7, model_csr[CSR_MEPC]);
      model_write(CSR_MSTATUS, return_status(model_csr[CSR_MSTATUS]));
      check_trap_csrs("mret");
    end
    end_test("mret return");

    for (i = 0; i < 2; i++) begin
      trap_pc = rand64();
      run_trap(OP_OTHER, trap_pc, 11, model_csr[CSR_MTVEC]);
      entry_model(trap_pc, CAUSE_ILLEGAL);
      check_trap_csrs("illegal");
    end
    end_test("illegal entry");

    csr_write(CSR_MTVEC, rand64());
    csr_write(CSR_MSTATUS, rand64() | 64'h8); // MIE on
    trap_pc = rand64();
    pc      = trap_pc;
    csr_write(CSR_MTIMECMP, mtime_model + 64'd8);
    wait_jmp(JMP_TIMEOUT, cycles);
    check(pc_jmpaddr, model_csr[CSR_MTVEC], "timer jump address");
    finish_done(1);
    check(timer_irq, 1'b0, "o_timer_irq after the trap");
    entry_model(trap_pc, CAUSE_TIMER_INT);
    check_trap_csrs("timer");
    end_test("timer interrupt");

    // port read lands in a sequencer setup cycle
    csr_write(CSR_MSCRATCH, rand64());
    trap_pc  = rand64();
    req_at   = $urandom_range(1, 9);
    opcode   = OP_ECALL;
    pc       = trap_pc;
    ena      = 1'b1;
    @(negedge clk);
    ena      = 1'b0;
    cycles   = 1;
    pending  = 1'b0;
    granted  = 1'b0;
    wait_cnt = 0;
    while (!pc_jmp && cycles < JMP_TIMEOUT) begin
      if (cycles == req_at) begin
        inst_req.addr = CSR_MSCRATCH;
        inst_req.ren  = 1'b1;
        pending       = 1'b1;
      end
      if (pending) begin
        #1;
        if (inst_grant) begin
          pending = 1'b0;
          granted = 1'b1;
          check(csr_rdata, model_csr[CSR_MSCRATCH], "mscratch read during trap");
        end else begin
          wait_cnt++;
        end
      end
      @(negedge clk);
      if (granted) begin
        inst_req = CSR_REQ_IDLE;
      end
      cycles++;
    end
    inst_req = CSR_REQ_IDLE;
    if (!pc_jmp) begin
      report_timeout("o_pc_jmp with a port request in flight");
    end else begin
      check(cycles, 11, "cycles to jump with port traffic");
      check(pc_jmpaddr, model_csr[CSR_MTVEC], "jump address with port traffic");
    end
    check(granted, 1'b1, "port request granted during trap");
    check(wait_cnt <= 1, 1'b1, "port waited more than one bus cycle");
    finish_done($urandom_range(2, 5));
    entry_model(trap_pc, CAUSE_ECALL_M);
    check_trap_csrs("port traffic");
    end_test("port during trap");

    $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
             tests, failed_tests, errors, timeouts);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- project.f
design/csr_pkg.sv
design/trap_pkg.sv
design/trap_sequencer.sv
design/csr_bus_arbiter.sv
design/csr_file.sv
design/machine_timer.sv
design/trap_unit_top.sv
test/trap_tb.sv
